// File: Bender.yml
package:
  name: exe_stage

sources:
  - files:
      - logic/rv_isa_pkg.sv
      - logic/exe_pkg.sv
      - logic/exe_op_if.sv
      - logic/exe_alu.sv
      - logic/exe_branch.sv
      - logic/exe_lsu_addr.sv
      - logic/exe_top.sv
  - target: test
    files:
      - verif/exe_assert.sv
      - verif/exe_tb.sv

// File: list.f
logic/rv_isa_pkg.sv
logic/exe_pkg.sv
logic/exe_op_if.sv
logic/exe_alu.sv
logic/exe_branch.sv
logic/exe_lsu_addr.sv
logic/exe_top.sv
verif/exe_assert.sv
verif/exe_tb.sv

// File: logic/exe_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exe_alu #(
    parameter int XLEN = 32
) (
    exe_op_if.unit               op_i,
    output logic                 reg_we_o,
    output rv_isa_pkg::reg_idx_t reg_waddr_o,
    output logic [XLEN-1:0]      reg_wdata_o
);
    import rv_isa_pkg::*;

    localparam int SHW = $clog2(XLEN);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] sr_shift;
    logic [XLEN-1:0] sr_mask;
    logic [XLEN-1:0] sra_val;
    logic            lt_s;
    logic            lt_u;
    logic            is_r;

    assign opcode = op_i.inst[6:0];
    assign funct3 = op_i.inst[14:12];
    assign funct7 = op_i.inst[31:25];
    assign shamt  = op_i.op2[SHW-1:0];

    assign sr_shift = op_i.op1 >> shamt;
    assign sr_mask  = {XLEN{1'b1}} >> shamt;
    assign sra_val  = (sr_shift & sr_mask) | ({XLEN{op_i.op1[XLEN-1]}} & ~sr_mask);

    assign lt_s = $signed(op_i.op1) < $signed(op_i.op2);
    assign lt_u = op_i.op1 < op_i.op2;
    assign is_r = (funct7 == F7_BASE) || (funct7 == F7_ALT); // anything else is M-type

    always_comb begin
        reg_we_o    = 1'b0;
        reg_waddr_o = ZERO_REG;
        reg_wdata_o = '0;
        case (opcode)
            OPC_I, OPC_R: begin
                if (opcode == OPC_I || is_r) begin
                    reg_waddr_o = op_i.reg_waddr;
                    reg_we_o    = 1'b1;
                    case (funct3)
                        F3_ADD: begin
                            if (opcode == OPC_R && funct7 == F7_ALT) begin
                                reg_wdata_o = op_i.op1 - op_i.op2;
                            end else begin
                                reg_wdata_o = op_i.op1 + op_i.op2;
                            end
                        end
                        F3_SLL: begin
                            reg_wdata_o = op_i.op1 << shamt;
                            if (opcode == OPC_I && funct7 != F7_BASE) begin
                                reg_we_o    = 1'b0; // bad slli encoding
                                reg_waddr_o = ZERO_REG;
                                reg_wdata_o = '0;
                            end
                        end
                        F3_SLT:  reg_wdata_o = {{(XLEN-1){1'b0}}, lt_s};
                        F3_SLTU: reg_wdata_o = {{(XLEN-1){1'b0}}, lt_u};
                        F3_XOR:  reg_wdata_o = op_i.op1 ^ op_i.op2;
                        F3_SR: begin
                            if (funct7 == F7_BASE) begin
                                reg_wdata_o = sr_shift;
                            end else if (funct7 == F7_ALT) begin
                                reg_wdata_o = sra_val;
                            end else begin
                                reg_we_o    = 1'b0;
                                reg_waddr_o = ZERO_REG;
                            end
                        end
                        F3_OR:   reg_wdata_o = op_i.op1 | op_i.op2;
                        default: reg_wdata_o = op_i.op1 & op_i.op2; // and
                    endcase
                end
            end
            OPC_LUI, OPC_AUIPC: begin
                reg_waddr_o = op_i.reg_waddr;
                reg_wdata_o = op_i.op1 + op_i.op2; // decode set up the operands
                reg_we_o    = op_i.reg_we;
            end
            OPC_L: begin
                reg_waddr_o = op_i.reg_waddr; // data filled in by mem stage
                reg_we_o    = 1'b1;
            end
            OPC_S:   reg_waddr_o = op_i.reg_waddr;
            OPC_JAL, OPC_JALR: begin
                reg_waddr_o = op_i.reg_waddr;
                reg_wdata_o = op_i.inst_addr + XLEN'(4);
                reg_we_o    = 1'b1;
            end
            OPC_SYSTEM: reg_waddr_o = ZERO_REG; // no csr support
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/exe_branch.sv
`timescale 1ns/1ps
`default_nettype none

module exe_branch #(
    parameter int XLEN = 32
) (
    exe_op_if.unit          op_i,
    output logic            jump_en_o,
    output logic [XLEN-1:0] jump_addr_o
);
    import rv_isa_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] jalr_sum;
    logic            eq;
    logic            ge_s;
    logic            ge_u;
    logic            taken;

    assign opcode = op_i.inst[6:0];
    assign funct3 = op_i.inst[14:12];

    assign b_imm = {{(XLEN-12){op_i.inst[31]}}, op_i.inst[7], op_i.inst[30:25],
                    op_i.inst[11:8], 1'b0};
    assign j_imm = {{(XLEN-20){op_i.inst[31]}}, op_i.inst[19:12], op_i.inst[20],
                    op_i.inst[30:21], 1'b0};
    assign i_imm = {{(XLEN-12){op_i.inst[31]}}, op_i.inst[31:20]};
    assign jalr_sum = op_i.op1 + i_imm;

    assign eq   = op_i.op1 == op_i.op2;
    assign ge_s = $signed(op_i.op1) >= $signed(op_i.op2);
    assign ge_u = op_i.op1 >= op_i.op2;

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = eq;
            F3_BNE:  taken = ~eq;
            F3_BLT:  taken = ~ge_s;
            F3_BGE:  taken = ge_s;
            F3_BLTU: taken = ~ge_u;
            F3_BGEU: taken = ge_u;
            default: taken = 1'b0; // reserved encodings
        endcase
    end

    always_comb begin
        jump_en_o   = 1'b0;
        jump_addr_o = '0;
        if (opcode == OPC_B && taken) begin
            jump_en_o   = 1'b1;
            jump_addr_o = op_i.inst_addr + b_imm;
        end else if (opcode == OPC_JAL) begin
            jump_en_o   = 1'b1;
            jump_addr_o = op_i.inst_addr + j_imm;
        end else if (opcode == OPC_JALR) begin
            jump_en_o   = 1'b1;
            jump_addr_o = {jalr_sum[XLEN-1:1], 1'b0}; // lsb forced low
        end
    end

endmodule

`default_nettype wire

// File: logic/exe_lsu_addr.sv
`timescale 1ns/1ps
`default_nettype none

module exe_lsu_addr #(
    parameter int XLEN = 32
) (
    exe_op_if.unit           op_i,
    output logic             mem_we_o,
    output logic [XLEN-1:0]  mem_addr_o,
    output logic [XLEN-1:0]  mem_wdata_o,
    output exe_pkg::mem_op_e mem_op_o
);
    import rv_isa_pkg::*;
    import exe_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] l_imm;

    assign opcode = op_i.inst[6:0];
    assign funct3 = op_i.inst[14:12];
    assign s_imm  = {{(XLEN-12){op_i.inst[31]}}, op_i.inst[31:25], op_i.inst[11:7]};
    assign l_imm  = {{(XLEN-12){op_i.inst[31]}}, op_i.inst[31:20]};

    always_comb begin
        mem_we_o    = 1'b0;
        mem_addr_o  = '0;
        mem_wdata_o = '0;
        mem_op_o    = MEM_NOP;
        if (opcode == OPC_S) begin
            mem_we_o = 1'b1; // stays set even for a bad funct3
            if (funct3 == F3_SB || funct3 == F3_SH || funct3 == F3_SW) begin
                mem_addr_o  = op_i.op1 + s_imm;
                mem_wdata_o = op_i.op2;
                mem_op_o    = (funct3 == F3_SB) ? SB : (funct3 == F3_SH) ? SH : SW;
            end
        end else if (opcode == OPC_L) begin
            mem_addr_o = op_i.op1 + l_imm;
            case (funct3)
                F3_LB:   mem_op_o = LB;
                F3_LH:   mem_op_o = LH;
                F3_LW:   mem_op_o = LW;
                F3_LBU:  mem_op_o = LBU;
                F3_LHU:  mem_op_o = LHU;
                default: mem_addr_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/exe_op_if.sv
`timescale 1ns/1ps
`default_nettype none

// one issued instruction with operands already read
interface exe_op_if #(
    parameter int XLEN = 32
);

    logic [31:0]          inst;
    logic [XLEN-1:0]      inst_addr;
    logic [XLEN-1:0]      op1;
    logic [XLEN-1:0]      op2;
    rv_isa_pkg::reg_idx_t reg_waddr;
    logic                 reg_we;

    modport src (
        output inst, inst_addr, op1, op2, reg_waddr, reg_we
    );

    modport unit (
        input inst, inst_addr, op1, op2, reg_waddr, reg_we
    );

endinterface

`default_nettype wire

// File: logic/exe_pkg.sv
`default_nettype none

package exe_pkg;

    localparam int XLEN_DEF = 32;

    // access kind sent to the memory stage
    typedef enum logic [3:0] {
        MEM_NOP = 4'd0,
        LB      = 4'd1,
        LH      = 4'd2,
        LW      = 4'd3,
        LBU     = 4'd4,
        LHU     = 4'd5,
        SB      = 4'd6,
        SH      = 4'd7,
        SW      = 4'd8
    } mem_op_e;

endpackage

`default_nettype wire

// File: logic/exe_top.sv
`timescale 1ns/1ps
`default_nettype none

module exe_top #(
    parameter int XLEN = exe_pkg::XLEN_DEF
) (
    input  wire                  clk_i,
    input  wire                  rst_i,

    input  wire                  in_valid_i,
    output logic                 in_ready_o,
    input  wire [31:0]           inst_i,
    input  wire [XLEN-1:0]       inst_addr_i,
    input  wire [XLEN-1:0]       op1_i,
    input  wire [XLEN-1:0]       op2_i,
    input  rv_isa_pkg::reg_idx_t reg_waddr_i,
    input  wire                  reg_we_i,

    output logic                 out_valid_o,
    input  wire                  out_ready_i,
    output logic                 reg_we_o,
    output rv_isa_pkg::reg_idx_t reg_waddr_o,
    output logic [XLEN-1:0]      reg_wdata_o,
    output logic                 mem_we_o,
    output logic [XLEN-1:0]      mem_addr_o,
    output logic [XLEN-1:0]      mem_wdata_o,
    output exe_pkg::mem_op_e     mem_op_o,
    output logic                 jump_en_o,
    output logic [XLEN-1:0]      jump_addr_o
);
    import rv_isa_pkg::*;
    import exe_pkg::*;

    logic            accept;
    logic            alu_reg_we;
    reg_idx_t        alu_reg_waddr;
    logic [XLEN-1:0] alu_reg_wdata;
    logic            lsu_mem_we;
    logic [XLEN-1:0] lsu_mem_addr;
    logic [XLEN-1:0] lsu_mem_wdata;
    mem_op_e         lsu_mem_op;
    logic            br_jump_en;
    logic [XLEN-1:0] br_jump_addr;

    exe_op_if #(.XLEN(XLEN)) op_bus ();

    assign op_bus.inst      = inst_i;
    assign op_bus.inst_addr = inst_addr_i;
    assign op_bus.op1       = op1_i;
    assign op_bus.op2       = op2_i;
    assign op_bus.reg_waddr = reg_waddr_i;
    assign op_bus.reg_we    = reg_we_i;

    // room when empty or draining this cycle
    assign in_ready_o = ~out_valid_o | out_ready_i;
    assign accept     = in_valid_i & in_ready_o;

    exe_alu #(.XLEN(XLEN)) u_alu (
        .op_i        (op_bus.unit),
        .reg_we_o    (alu_reg_we),
        .reg_waddr_o (alu_reg_waddr),
        .reg_wdata_o (alu_reg_wdata)
    );

    exe_branch #(.XLEN(XLEN)) u_branch (
        .op_i        (op_bus.unit),
        .jump_en_o   (br_jump_en),
        .jump_addr_o (br_jump_addr)
    );

    exe_lsu_addr #(.XLEN(XLEN)) u_lsu_addr (
        .op_i        (op_bus.unit),
        .mem_we_o    (lsu_mem_we),
        .mem_addr_o  (lsu_mem_addr),
        .mem_wdata_o (lsu_mem_wdata),
        .mem_op_o    (lsu_mem_op)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
            reg_we_o    <= 1'b0;
            mem_we_o    <= 1'b0;
            jump_en_o   <= 1'b0;
        end else if (accept) begin
            out_valid_o <= 1'b1;
            reg_we_o    <= alu_reg_we;
            mem_we_o    <= lsu_mem_we;
            jump_en_o   <= br_jump_en;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0; // result left, nothing new
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            reg_waddr_o <= alu_reg_waddr;
            reg_wdata_o <= alu_reg_wdata;
            mem_addr_o  <= lsu_mem_addr;
            mem_wdata_o <= lsu_mem_wdata;
            mem_op_o    <= lsu_mem_op;
            jump_addr_o <= br_jump_addr;
        end
    end

endmodule

`default_nettype wire

// File: logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [4:0] reg_idx_t;

    localparam reg_idx_t ZERO_REG = 5'd0;

    // major opcodes
    localparam logic [6:0] OPC_I      = 7'b0010011;
    localparam logic [6:0] OPC_R      = 7'b0110011; // shared with M extension
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_S      = 7'b0100011;
    localparam logic [6:0] OPC_L      = 7'b0000011;
    localparam logic [6:0] OPC_B      = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // alu funct3, same for reg and imm forms
    localparam logic [2:0] F3_ADD  = 3'b000; // also SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // SRL and SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load kinds
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // store kinds
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

endpackage

`default_nettype wire

// File: verif/exe_assert.sv
`timescale 1ns/1ps
`default_nettype none

module exe_assert #(
    parameter int XLEN = 32
) (
    input wire               clk_i,
    input wire               rst_i,
    input wire               in_valid_i,
    input wire               in_ready_i,
    input wire               out_valid_i,
    input wire               out_ready_i,
    input wire [4*XLEN+11:0] result_i // all registered outputs
);

    property hold_while_stalled;
        @(posedge clk_i) disable iff (rst_i)
            (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(result_i));
    endproperty

    property empty_after_reset;
        @(posedge clk_i) rst_i |=> !out_valid_i;
    endproperty

    // accepted instruction shows up the next cycle
    property accept_fills;
        @(posedge clk_i) disable iff (rst_i)
            (in_valid_i && in_ready_i) |=> out_valid_i;
    endproperty

    hold_check: assert property (hold_while_stalled)
        else $error("output register changed while stalled");

    reset_check: assert property (empty_after_reset)
        else $error("out_valid_o high in the cycle after reset");

    accept_check: assert property (accept_fills)
        else $error("accepted instruction did not reach the output register");

endmodule

bind exe_top exe_assert #(.XLEN(XLEN)) u_assert (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_i    ({reg_we_o, reg_waddr_o, reg_wdata_o, mem_we_o, mem_addr_o,
                   mem_wdata_o, mem_op_o, jump_en_o, jump_addr_o})
);

`default_nettype wire

// File: verif/exe_input.txt
// in:  inst inst_addr op1 op2 reg_waddr reg_we
// exp: reg_we reg_waddr reg_wdata mem_we mem_addr mem_wdata mem_op jump_en jump_addr
00510093 00000000 00000010 00000005 01 1 1 01 00000015 0 00000000 00000000 0 0 00000000
005201B3 00000000 7FFFFFFF 00000001 03 1 1 03 80000000 0 00000000 00000000 0 0 00000000
405201B3 00000000 00000003 00000005 03 1 1 03 FFFFFFFE 0 00000000 00000000 0 0 00000000
0083A333 00000000 FFFFFFF0 00000002 06 1 1 06 00000001 0 00000000 00000000 0 0 00000000
0083B333 00000000 FFFFFFF0 00000002 06 1 1 06 00000000 0 00000000 00000000 0 0 00000000
40B554B3 00000000 80000F00 00000004 09 1 1 09 F80000F0 0 00000000 00000000 0 0 00000000
00B554B3 00000000 80000F00 00000004 09 1 1 09 080000F0 0 00000000 00000000 0 0 00000000
00B514B3 00000000 00000003 0000001F 09 1 1 09 80000000 0 00000000 00000000 0 0 00000000
00E6C633 00000000 F0F0F0F0 0FF00FF0 0C 1 1 0C FF00FF00 0 00000000 00000000 0 0 00000000
00F6E613 00000000 12345670 0000000F 0C 1 1 0C 1234567F 0 00000000 00000000 0 0 00000000
0FF6F613 00000000 12345678 000000FF 0C 1 1 0C 00000078 0 00000000 00000000 0 0 00000000
02455493 00000000 80000F00 00000004 09 1 0 00 00000000 0 00000000 00000000 0 0 00000000
40451493 00000000 00000003 00000004 09 1 0 00 00000000 0 00000000 00000000 0 0 00000000
FFC32283 00000000 00001000 00000000 05 1 1 05 00000000 0 00000FFC 00000000 3 0 00000000
01034283 00000000 00002000 00000000 05 1 1 05 00000000 0 00002010 00000000 4 0 00000000
00742423 00000000 00003000 DEADBEEF 00 0 0 00 00000000 1 00003008 DEADBEEF 8 0 00000000
FE740FA3 00000000 00003000 000000AB 00 0 0 00 00000000 1 00002FFF 000000AB 6 0 00000000
00208863 00000100 00000055 00000055 00 0 0 00 00000000 0 00000000 00000000 0 1 00000110
00209863 00000100 00000055 00000055 00 0 0 00 00000000 0 00000000 00000000 0 0 00000000
FE20CCE3 00000200 FFFFFFFF 00000001 00 0 0 00 00000000 0 00000000 00000000 0 1 000001F8
FE20DCE3 00000200 FFFFFFFF 00000001 00 0 0 00 00000000 0 00000000 00000000 0 0 00000000
FE20ECE3 00000200 FFFFFFFF 00000001 00 0 0 00 00000000 0 00000000 00000000 0 0 00000000
FE20FCE3 00000200 FFFFFFFF 00000001 00 0 0 00 00000000 0 00000000 00000000 0 1 000001F8
001000EF 00001000 00000000 00000000 01 1 1 01 00001004 0 00000000 00000000 0 1 00001800
003280E7 00000300 00004000 00000003 01 1 1 01 00000304 0 00000000 00000000 0 1 00004002
025201B3 00000000 00000003 00000005 03 1 0 00 00000000 0 00000000 00000000 0 0 00000000
00000073 00000000 00000000 00000000 00 0 0 00 00000000 0 00000000 00000000 0 0 00000000
12345537 00000000 00000000 12345000 0A 1 1 0A 12345000 0 00000000 00000000 0 0 00000000
00001517 00000400 00000400 00001000 0A 1 1 0A 00001400 0 00000000 00000000 0 0 00000000

// File: verif/exe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exe_tb;
    import exe_pkg::*;

    localparam int XLEN    = 32;
    localparam int MAX_VEC = 64;
    localparam int TIMEOUT = 200; // cycles per wait

    logic            clk;
    logic            rst;
    logic            in_valid;
    logic            in_ready;
    logic [31:0]     inst;
    logic [XLEN-1:0] inst_addr;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [4:0]      reg_waddr_in;
    logic            reg_we_in;
    logic            out_valid;
    logic            out_ready;
    logic            reg_we;
    logic [4:0]      reg_waddr;
    logic [XLEN-1:0] reg_wdata;
    logic            mem_we;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    mem_op_e         mem_op;
    logic            jump_en;
    logic [XLEN-1:0] jump_addr;

    // vector table, inputs then expected results
    logic [31:0] v_inst [MAX_VEC];
    logic [31:0] v_addr [MAX_VEC];
    logic [31:0] v_op1 [MAX_VEC];
    logic [31:0] v_op2 [MAX_VEC];
    logic [4:0]  v_waddr [MAX_VEC];
    logic        v_we [MAX_VEC];
    logic        e_reg_we [MAX_VEC];
    logic [4:0]  e_reg_waddr [MAX_VEC];
    logic [31:0] e_reg_wdata [MAX_VEC];
    logic        e_mem_we [MAX_VEC];
    logic [31:0] e_mem_addr [MAX_VEC];
    logic [31:0] e_mem_wdata [MAX_VEC];
    logic [3:0]  e_mem_op [MAX_VEC];
    logic        e_jump_en [MAX_VEC];
    logic [31:0] e_jump_addr [MAX_VEC];

    int     num_vec;
    int     received;
    int     errors;
    int     checks;
    bit     timed_out;
    integer seed;

    exe_top #(.XLEN(XLEN)) uut (
        .clk_i       (clk),
        .rst_i       (rst),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .inst_i      (inst),
        .inst_addr_i (inst_addr),
        .op1_i       (op1),
        .op2_i       (op2),
        .reg_waddr_i (reg_waddr_in),
        .reg_we_i    (reg_we_in),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .reg_we_o    (reg_we),
        .reg_waddr_o (reg_waddr),
        .reg_wdata_o (reg_wdata),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_op_o    (mem_op),
        .jump_en_o   (jump_en),
        .jump_addr_o (jump_addr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random back-pressure from downstream
    initial begin
        seed      = 83;
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_ready = ($random(seed) % 2) != 0;
        end
    end

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        fd = $fopen("verif/exe_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the vector file verif/exe_input.txt");
        end else begin
            while (!$feof(fd) && num_vec < MAX_VEC) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "/") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                v_inst[num_vec], v_addr[num_vec], v_op1[num_vec],
                                v_op2[num_vec], v_waddr[num_vec], v_we[num_vec],
                                e_reg_we[num_vec], e_reg_waddr[num_vec],
                                e_reg_wdata[num_vec], e_mem_we[num_vec],
                                e_mem_addr[num_vec], e_mem_wdata[num_vec],
                                e_mem_op[num_vec], e_jump_en[num_vec],
                                e_jump_addr[num_vec]);
                    if (n == 15) begin
                        num_vec++;
                    end else begin
                        errors++;
                        $display("malformed line in vector file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        if (num_vec == 0) begin
            errors++;
            $display("no vectors were loaded");
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual, inout bit ok);
        checks++;
        if (actual !== expected) begin
            errors++;
            ok = 1'b0;
            $display("Fail time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_reset();
        bit ok;
        ok = 1'b1;
        @(negedge clk);
        compare_field("out_valid_o", 32'd0, out_valid, ok);
        compare_field("in_ready_o", 32'd1, in_ready, ok);
        compare_field("reg_we_o", 32'd0, reg_we, ok);
        compare_field("mem_we_o", 32'd0, mem_we, ok);
        compare_field("jump_en_o", 32'd0, jump_en, ok);
        $display("reset: %s", ok ? "ok" : "mismatch");
    endtask

    task automatic check_result(input int idx);
        bit ok;
        ok = 1'b1;
        compare_field("reg_we_o", e_reg_we[idx], reg_we, ok);
        compare_field("reg_waddr_o", e_reg_waddr[idx], reg_waddr, ok);
        compare_field("reg_wdata_o", e_reg_wdata[idx], reg_wdata, ok);
        compare_field("mem_we_o", e_mem_we[idx], mem_we, ok);
        compare_field("mem_addr_o", e_mem_addr[idx], mem_addr, ok);
        compare_field("mem_wdata_o", e_mem_wdata[idx], mem_wdata, ok);
        compare_field("mem_op_o", e_mem_op[idx], mem_op, ok);
        compare_field("jump_en_o", e_jump_en[idx], jump_en, ok);
        compare_field("jump_addr_o", e_jump_addr[idx], jump_addr, ok);
        $display("vector %0d inst %08h mem_op %s: %s", idx, v_inst[idx], mem_op.name(),
                 ok ? "ok" : "mismatch");
    endtask

    task automatic drive_vectors();
        int i;
        int wait_cycles;
        bit accepted;
        @(posedge clk);
        #1;
        for (i = 0; i < num_vec && !timed_out; i++) begin
            in_valid     = 1'b1;
            inst         = v_inst[i];
            inst_addr    = v_addr[i];
            op1          = v_op1[i];
            op2          = v_op2[i];
            reg_waddr_in = v_waddr[i];
            reg_we_in    = v_we[i];
            accepted     = 1'b0;
            wait_cycles  = 0;
            while (!accepted && wait_cycles < TIMEOUT) begin
                @(negedge clk);
                accepted = in_ready; // taken at the coming edge
                @(posedge clk);
                #1;
                wait_cycles++;
            end
            if (!accepted) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: vector %0d not accepted within %0d cycles", i, TIMEOUT);
            end
        end
        in_valid = 1'b0;
    endtask

    // a result leaves at the edge after a negedge with valid and ready
    task automatic collect_results();
        int idle;
        idle = 0;
        while (received < num_vec && idle < TIMEOUT && !timed_out) begin
            @(negedge clk);
            if (out_valid && out_ready) begin
                check_result(received);
                received++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (received < num_vec && !timed_out) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: no result for vector %0d within %0d cycles", received, TIMEOUT);
        end
    endtask

    task automatic check_no_extra();
        int i;
        bit ok;
        ok = 1'b1;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                ok = 1'b0;
                errors++;
                $display("an extra result was presented after the last vector at %0t", $time);
            end
        end
        if (received != num_vec) begin
            ok = 1'b0;
            errors++;
            $display("received %0d results for %0d vectors", received, num_vec);
        end
        $display("order and count: %s", ok ? "ok" : "mismatch");
    endtask

    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        inst         = '0;
        inst_addr    = '0;
        op1          = '0;
        op2          = '0;
        reg_waddr_in = '0;
        reg_we_in    = 1'b0;
        num_vec      = 0;
        received     = 0;
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;
        load_vectors();
        apply_reset();
        check_reset();
        fork
            drive_vectors();
            collect_results();
        join
        check_no_extra();
        $display("vectors %0d, results %0d, checks %0d, errors %0d",
                 num_vec, received, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
